// File: verilog/fetch_pkg.sv
//------------------------------
// Shared constants and message types for the fetch subsystem
// Word addressed memory of MEM_WORDS words, index from addr[6:2]
// NUM_SEQ must be a power of two and equal 2**SEQ_NUM_BITS
//------------------------------

package fetch_pkg;

  //------------------------------
  // Fetch parameters
  //------------------------------

  // First fetch address after reset
  localparam logic [31:0] RST_ADDR = 32'h0000_0200;

  // Outstanding memory reads
  localparam int MAX_IN_FLIGHT = 4;
  localparam int INFLIGHT_BITS = 3;

  // Edge of acceptance to earliest response
  localparam int MEM_LATENCY = 2;

  // ROM depth, wraps every 128 bytes
  localparam int MEM_WORDS = 32;

  //------------------------------
  // Sequence numbers
  //------------------------------

  localparam int SEQ_NUM_BITS  = 4;
  localparam int NUM_SEQ       = 16;
  localparam int RECLAIM_WIDTH = 2;

  //------------------------------
  // Message types
  //------------------------------

  // Read request, no write data
  typedef struct packed {
    logic [31:0] addr;
  } mem_req_t;

  // Read response, echoes the request address
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
  } mem_resp_t;

  // Fetch to decode
  typedef struct packed {
    logic [31:0]             pc;
    logic [31:0]             inst;
    logic [SEQ_NUM_BITS-1:0] seq_num;
  } f_d_msg_t;

  // One retired instruction
  typedef struct packed {
    logic                    val;
    logic [SEQ_NUM_BITS-1:0] seq_num;
  } commit_lane_t;

  // Lanes fill from index 0
  typedef commit_lane_t [RECLAIM_WIDTH-1:0] commit_notif_t;

endpackage

// File: verilog/seq_num_gen.sv
//------------------------------
// Circular sequence number allocator
// Commits must retire numbers in allocation order
// Only the count of valid lanes is used on reclaim
//------------------------------

`timescale 1ns/1ns

module seq_num_gen import fetch_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,

  // Allocation side
  input  logic                    alloc_rdy,
  output logic                    alloc_val,
  output logic [SEQ_NUM_BITS-1:0] alloc_seq_num,

  // Retirement side, no backpressure
  input  commit_notif_t           commit
);

  //------------------------------
  // State
  //------------------------------

  // Next number to hand out
  logic [SEQ_NUM_BITS-1:0] head;

  // Numbers handed out and not yet retired, 0..NUM_SEQ
  logic [SEQ_NUM_BITS:0]   num_out;
  logic [SEQ_NUM_BITS:0]   num_out_next;

  logic                    alloc_xfer;
  logic [SEQ_NUM_BITS:0]   reclaim_cnt;

  //------------------------------
  // Allocation
  //------------------------------

  // Free while not every number is outstanding
  assign alloc_val     = (num_out < (SEQ_NUM_BITS+1)'(NUM_SEQ));
  assign alloc_seq_num = head;
  assign alloc_xfer    = alloc_val & alloc_rdy;

  // Head wraps modulo NUM_SEQ
  always_ff @(posedge clk) begin
    if (rst) begin
      head <= '0;
    end else if (alloc_xfer) begin
      head <= head + SEQ_NUM_BITS'(1);
    end
  end

  //------------------------------
  // Reclaim
  //------------------------------

  // Count valid lanes; order is trusted
  always_comb begin
    reclaim_cnt = '0;
    for (int i = 0; i < RECLAIM_WIDTH; i++) begin
      reclaim_cnt = reclaim_cnt + (SEQ_NUM_BITS+1)'(commit[i].val);
    end
  end

  // Allocate and reclaim fold into one update
  always_comb begin
    num_out_next = num_out + (SEQ_NUM_BITS+1)'(alloc_xfer) - reclaim_cnt;
  end

  // Reclaimed numbers free up at the next edge
  always_ff @(posedge clk) begin
    if (rst) begin
      num_out <= '0;
    end else begin
      num_out <= num_out_next;
    end
  end

endmodule

// File: verilog/fetch_unit.sv
//------------------------------
// Sequential fetch with an increment-only PC
// At most MAX_IN_FLIGHT reads outstanding
// Decode path is combinational from the memory response
//------------------------------

`timescale 1ns/1ns

module fetch_unit import fetch_pkg::*; (
  input  logic          clk,
  input  logic          rst,

  // Memory request
  output logic          mem_req_val,
  input  logic          mem_req_rdy,
  output mem_req_t      mem_req,

  // Memory response
  input  logic          mem_resp_val,
  output logic          mem_resp_rdy,
  input  mem_resp_t     mem_resp,

  // To decode
  output logic          d_val,
  input  logic          d_rdy,
  output f_d_msg_t      d_msg,

  // From commit
  input  commit_notif_t commit
);

  //------------------------------
  // Request side
  //------------------------------

  logic                     req_xfer;
  logic                     resp_xfer;
  logic [INFLIGHT_BITS-1:0] num_in_flight;
  logic [31:0]              pc;

  assign req_xfer  = mem_req_val & mem_req_rdy;
  assign resp_xfer = mem_resp_val & mem_resp_rdy;

  // Reads outstanding between request and response transfer
  always_ff @(posedge clk) begin
    if (rst) begin
      num_in_flight <= '0;
    end else if (req_xfer && !resp_xfer) begin
      num_in_flight <= num_in_flight + INFLIGHT_BITS'(1);
    end else if (resp_xfer && !req_xfer) begin
      num_in_flight <= num_in_flight - INFLIGHT_BITS'(1);
    end
  end

  // Next word address
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RST_ADDR;
    end else if (req_xfer) begin
      pc <= pc + 32'd4;
    end
  end

  // First request goes out in the first cycle after reset
  assign mem_req_val  = !rst && (num_in_flight < INFLIGHT_BITS'(MAX_IN_FLIGHT));
  assign mem_req.addr = pc;

  //------------------------------
  // Response side
  //------------------------------

  logic                    alloc_val;
  logic                    alloc_rdy;
  logic [SEQ_NUM_BITS-1:0] alloc_seq_num;

  // Allocate only when the instruction is actually leaving
  assign alloc_rdy = d_rdy & mem_resp_val;

  // No free number stalls both decode and the memory queue
  assign d_val        = mem_resp_val & alloc_val;
  assign mem_resp_rdy = d_rdy & alloc_val;

  always_comb begin
    d_msg.pc      = mem_resp.addr;
    d_msg.inst    = mem_resp.data;
    d_msg.seq_num = alloc_seq_num;
  end

  seq_num_gen i_seq_num_gen (
    .clk           (clk),
    .rst           (rst),
    .alloc_rdy     (alloc_rdy),
    .alloc_val     (alloc_val),
    .alloc_seq_num (alloc_seq_num),
    .commit        (commit)
  );

endmodule

// File: verilog/inst_mem.sv
//------------------------------
// Read-only instruction memory, image from inst_mem.hex in the run dir
// Index is addr[6:2], upper address bits are ignored
// Queue never overflows if the client keeps MAX_IN_FLIGHT reads
//------------------------------

`timescale 1ns/1ns

module inst_mem import fetch_pkg::*; (
  input  logic      clk,
  input  logic      rst,

  // Request port
  input  logic      req_val,
  output logic      req_rdy,
  input  mem_req_t  req,

  // Response port, in request order
  output logic      resp_val,
  input  logic      resp_rdy,
  output mem_resp_t resp
);

  //------------------------------
  // ROM
  //------------------------------

  logic [31:0] rom [MEM_WORDS];

  initial begin
    $readmemh("inst_mem.hex", rom);
  end

  //------------------------------
  // Latency pipeline
  //------------------------------

  logic                   req_xfer;
  logic [MEM_LATENCY-1:0] pipe_val;
  mem_resp_t              pipe_data [MEM_LATENCY];

  assign req_xfer = req_val & req_rdy;

  // Valid bits reset, payload just follows
  always_ff @(posedge clk) begin
    if (rst) begin
      pipe_val <= '0;
    end else begin
      pipe_val[0] <= req_xfer;
      for (int i = 1; i < MEM_LATENCY; i++) begin
        pipe_val[i] <= pipe_val[i-1];
      end
    end
  end

  // Word read at acceptance
  always_ff @(posedge clk) begin
    pipe_data[0].addr <= req.addr;
    pipe_data[0].data <= rom[req.addr[6:2]];
    for (int i = 1; i < MEM_LATENCY; i++) begin
      pipe_data[i] <= pipe_data[i-1];
    end
  end

  //------------------------------
  // Response queue
  //------------------------------

  mem_resp_t                q [MAX_IN_FLIGHT];
  logic [INFLIGHT_BITS-2:0] wr_ptr;
  logic [INFLIGHT_BITS-2:0] rd_ptr;
  logic [INFLIGHT_BITS-1:0] q_cnt;
  logic                     q_wr;
  logic                     q_rd;

  assign q_wr = pipe_val[MEM_LATENCY-1];
  assign q_rd = resp_val & resp_rdy;

  // Pointers wrap with the power of two depth
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      q_cnt  <= '0;
    end else begin
      if (q_wr) wr_ptr <= wr_ptr + (INFLIGHT_BITS-1)'(1);
      if (q_rd) rd_ptr <= rd_ptr + (INFLIGHT_BITS-1)'(1);
      q_cnt <= q_cnt + INFLIGHT_BITS'(q_wr) - INFLIGHT_BITS'(q_rd);
    end
  end

  always_ff @(posedge clk) begin
    if (q_wr) begin
      q[wr_ptr] <= pipe_data[MEM_LATENCY-1];
    end
  end

  // Stalled head stays put until taken
  assign req_rdy  = (q_cnt != INFLIGHT_BITS'(MAX_IN_FLIGHT));
  assign resp_val = (q_cnt != '0);
  assign resp     = q[rd_ptr];

endmodule

// File: verilog/fetch_top.sv
//------------------------------
// Fetch unit joined to the instruction memory
// Decode and commit ports come from outside
//------------------------------

`timescale 1ns/1ns

module fetch_top import fetch_pkg::*; (
  input  logic          clk,
  input  logic          rst,

  // Decode port
  output logic          d_val,
  input  logic          d_rdy,
  output f_d_msg_t      d_msg,

  // Retirement notices
  input  commit_notif_t commit
);

  // Memory request and response wires
  logic      mem_req_val;
  logic      mem_req_rdy;
  mem_req_t  mem_req;
  logic      mem_resp_val;
  logic      mem_resp_rdy;
  mem_resp_t mem_resp;

  fetch_unit i_fetch_unit (
    .clk          (clk),
    .rst          (rst),
    .mem_req_val  (mem_req_val),
    .mem_req_rdy  (mem_req_rdy),
    .mem_req      (mem_req),
    .mem_resp_val (mem_resp_val),
    .mem_resp_rdy (mem_resp_rdy),
    .mem_resp     (mem_resp),
    .d_val        (d_val),
    .d_rdy        (d_rdy),
    .d_msg        (d_msg),
    .commit       (commit)
  );

  inst_mem i_inst_mem (
    .clk      (clk),
    .rst      (rst),
    .req_val  (mem_req_val),
    .req_rdy  (mem_req_rdy),
    .req      (mem_req),
    .resp_val (mem_resp_val),
    .resp_rdy (mem_resp_rdy),
    .resp     (mem_resp)
  );

endmodule

// File: testbench/fetch_tb.sv
//------------------------------
// Testbench for fetch_top, acts as decode and commit
// Expects inst_mem.hex in the run directory
// Reference PC stream assumes no branches or redirects
//------------------------------

`timescale 1ns/1ns

module fetch_tb import fetch_pkg::*; ();

  localparam int TIMEOUT = 2000;

  logic          clk = 1'b0;
  logic          rst = 1'b1;
  logic          d_val;
  logic          d_rdy = 1'b0;
  f_d_msg_t      d_msg;
  commit_notif_t commit = '0;

  // Private copy of the ROM image
  logic [31:0] image [MEM_WORDS];

  // Traffic shape, set by the test sequence
  logic rdy_random  = 1'b0;
  int   commit_mode = 0;

  // Delivery index since last reset
  int                      deliv_cnt = 0;
  logic [SEQ_NUM_BITS-1:0] commit_q [$];

  int   err_data = 0;
  int   err_seq  = 0;
  int   err_ctl  = 0;
  int   pass_cnt = 0;
  int   fail_cnt = 0;
  logic stalled  = 1'b0;

  fetch_top i_fetch_top (
    .clk    (clk),
    .rst    (rst),
    .d_val  (d_val),
    .d_rdy  (d_rdy),
    .d_msg  (d_msg),
    .commit (commit)
  );

  // 100 ns period
  always #50 clk = ~clk;

  //------------------------------
  // Reference model
  //------------------------------

  // Delivery k: word k after reset, numbers wrap at NUM_SEQ
  function automatic f_d_msg_t expected_msg(input int k);
    f_d_msg_t m;
    m.pc      = RST_ADDR + 32'(4 * k);
    m.inst    = image[m.pc[6:2]];
    m.seq_num = SEQ_NUM_BITS'(k % NUM_SEQ);
    return m;
  endfunction

  function automatic int total_errors();
    return err_data + err_seq + err_ctl;
  endfunction

  //------------------------------
  // Decode sink, compare, commit driver
  //------------------------------

  always begin : decode_commit
    f_d_msg_t exp_m;
    int       n;
    // Sample mid-cycle, transfer happens at the next rising edge
    @(negedge clk);
    if (rst) begin
      deliv_cnt = 0;
      commit_q.delete();
    end else if (d_val && d_rdy) begin
      exp_m = expected_msg(deliv_cnt);
      assert (d_msg.pc == exp_m.pc) else begin
        $display("error: %0t d_msg.pc got %h expected %h", $time, d_msg.pc, exp_m.pc);
        err_data++;
      end
      assert (d_msg.inst == exp_m.inst) else begin
        $display("error: %0t d_msg.inst got %h expected %h", $time, d_msg.inst, exp_m.inst);
        err_data++;
      end
      assert (d_msg.seq_num == exp_m.seq_num) else begin
        $display("error: %0t d_msg.seq_num got %0d expected %0d",
                 $time, d_msg.seq_num, exp_m.seq_num);
        err_seq++;
      end
      commit_q.push_back(d_msg.seq_num);
      deliv_cnt++;
    end
    @(posedge clk);
    #5;
    d_rdy = rdy_random ? ($urandom_range(3) != 0) : 1'b1;
    // Oldest first, lane 0 filled first
    case (commit_mode)
      1:       n = RECLAIM_WIDTH;
      2:       n = int'($urandom_range(RECLAIM_WIDTH));
      default: n = 0;
    endcase
    commit = '0;
    for (int i = 0; i < RECLAIM_WIDTH; i++) begin
      if (i < n && commit_q.size() != 0) begin
        commit[i].val     = 1'b1;
        commit[i].seq_num = commit_q.pop_front();
      end
    end
  end

  //------------------------------
  // Helper tasks
  //------------------------------

  task automatic apply_reset();
    @(posedge clk);
    #5;
    rst = 1'b1;
    repeat (10) @(posedge clk);
    #5;
    rst = 1'b0;
  endtask

  task automatic wait_deliveries(input int target, input string what);
    int cycles;
    cycles = 0;
    while (deliv_cnt < target && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (deliv_cnt < target) begin
      $display("%0t: %s stalled, only %0d of %0d instructions delivered in %0d cycles",
               $time, what, deliv_cnt, target, cycles);
      err_ctl++;
      stalled = 1'b1;
    end
  endtask

  // No delivery may be offered while all numbers are out
  task automatic expect_idle(input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      assert (!d_val) else begin
        $display("error: %0t d_val got %b expected 0", $time, d_val);
        err_ctl++;
      end
    end
  endtask

  task automatic finish_test(input string name, input int errs);
    if (errs == 0) begin
      pass_cnt++;
      $display("test %s passed", name);
    end else begin
      fail_cnt++;
      $display("test %s failed with %0d errors", name, errs);
    end
  endtask

  //------------------------------
  // Test sequence
  //------------------------------

  initial begin : run_tests
    int base_data;
    int base_seq;
    int base_all;
    void'($urandom(81));
    $readmemh("inst_mem.hex", image);

    // Full speed, immediate commits, crosses the 128 byte wrap
    commit_mode = 1;
    base_data   = err_data + err_ctl;
    base_seq    = err_seq;
    apply_reset();
    wait_deliveries(40, "sequential fetch");
    finish_test("1 sequential fetch", err_data + err_ctl - base_data);
    finish_test("2 sequence numbering", err_seq - base_seq);

    // Commits withheld, fetch must stop at NUM_SEQ
    if (!stalled) begin
      base_all    = total_errors();
      commit_mode = 0;
      apply_reset();
      wait_deliveries(NUM_SEQ, "sequence exhaustion");
      expect_idle(200);
      assert (deliv_cnt == NUM_SEQ) else begin
        $display("error: %0t delivered count got %0d expected %0d",
                 $time, deliv_cnt, NUM_SEQ);
        err_ctl++;
      end
      finish_test("3 sequence exhaustion", total_errors() - base_all);
    end

    // Two retirements per cycle restart the stream at index 16
    if (!stalled) begin
      base_all    = total_errors();
      commit_mode = 1;
      wait_deliveries(32, "reclaim");
      finish_test("4 reclaim resumes fetch", total_errors() - base_all);
    end

    if (!stalled) begin
      base_all    = total_errors();
      rdy_random  = 1'b1;
      commit_mode = 2;
      wait_deliveries(deliv_cnt + 200, "random back-pressure");
      finish_test("5 random back-pressure", total_errors() - base_all);
    end

    // Reset with reads in flight and random traffic still running
    if (!stalled) begin
      base_all = total_errors();
      apply_reset();
      wait_deliveries(8, "reset mid-run");
      rdy_random = 1'b0;
      finish_test("6 reset mid-run", total_errors() - base_all);
    end

    $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && !stalled) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: inst_mem.hex
// One 32-bit instruction word per line, word index 0 to 31 in order
00FF0013
01FE0113
02FD0213
03FC0313
04FB0413
05FA0513
06F90613
07F80713
08F70813
09F60913
0AF50A13
0BF40B13
0CF30C13
0DF20D13
0EF10E13
0FF00F13
10EF1013
11EE1113
12ED1213
13EC1313
14EB1413
15EA1513
16E91613
17E81713
18E71813
19E61913
1AE51A13
1BE41B13
1CE31C13
1DE21D13
1EE11E13
1FE01F13

// File: files.f
verilog/fetch_pkg.sv
verilog/seq_num_gen.sv
verilog/fetch_unit.sv
verilog/inst_mem.sv
verilog/fetch_top.sv
testbench/fetch_tb.sv

// File: Makefile
# Verilator build and run of the fetch subsystem testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := fetch_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Runs from the project root so inst_mem.hex is found
run: $(SIM_BIN) inst_mem.hex
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then exit 1; fi
	@grep -qF '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
